// File: rtl/exec_pkg.sv
package exec_pkg;

    typedef enum logic [5:0] {
        // register-register
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLTU,
        OP_SLL, OP_SRL, OP_SRA, OP_ADDW, OP_SUBW, OP_SLLW,
        // register-immediate
        OP_ADDI, OP_SLLI, OP_SRLI, OP_SRAI, OP_SLTIU, OP_ADDIW,
        OP_LUI, OP_AUIPC,
        OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LD,
        OP_SB, OP_SH, OP_SW, OP_SD,
        // M extension subset
        OP_DIVU, OP_REMU, OP_MULW, OP_DIVW, OP_REMW,
        OP_EBREAK, OP_NOP
    } op_t;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLT, SLTU, SLL, SRL, SRA, SLLW
    } alu_mode_t;

    typedef enum logic [2:0] {
        DIVU, REMU, MULW, DIVW, REMW
    } md_fn_t;

    // imm arrives already sign-extended for its format
    typedef struct packed {
        logic        valid;
        op_t         op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [63:0] imm;
        logic [63:0] pc;
    } exec_op_t;

    typedef struct packed {
        logic [63:0] addr;
        logic [63:0] wdata;
        logic [7:0]  wmask;
        logic        we;
    } mem_req_t;

    typedef struct packed {
        logic        wen;
        logic [4:0]  rd;
        logic [63:0] wdata;
    } retire_t;

endpackage

// File: rtl/gpr_file.sv
module gpr_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic        wen,
    input  logic [63:0] wdata,
    output logic [63:0] src1,
    output logic [63:0] src2
);
    logic [63:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 64'd0;
            end
        end else if (wen && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 reads as zero
    assign src1 = (rs1 == 5'd0) ? 64'd0 : regs[rs1];
    assign src2 = (rs2 == 5'd0) ? 64'd0 : regs[rs2];

    a_x0_zero: assert property (
        @(posedge clk) disable iff (!rst_n) regs[0] == 64'd0
    );

endmodule

// File: rtl/int_alu.sv
module int_alu (
    input  exec_pkg::alu_mode_t mode,
    input  logic [63:0]         a,
    input  logic [63:0]         b,
    output logic [63:0]         result
);
    import exec_pkg::*;

    logic [5:0]  shamt;
    logic [31:0] sllw_res;

    assign shamt    = b[5:0];
    // low word only, sign extension happens in the caller
    assign sllw_res = a[31:0] << b[4:0];

    always_comb begin
        case (mode)
            ADD:     result = a + b;
            SUB:     result = a - b;
            AND:     result = a & b;
            OR:      result = a | b;
            XOR:     result = a ^ b;
            SLT:     result = {63'd0, $signed(a) < $signed(b)};
            SLTU:    result = {63'd0, a < b};
            SLL:     result = a << shamt;
            SRL:     result = a >> shamt;
            SRA:     result = $signed(a) >>> shamt;
            SLLW:    result = {32'd0, sllw_res};
            default: result = 64'd0;
        endcase
    end

endmodule

// File: rtl/int_muldiv.sv
module int_muldiv (
    input  exec_pkg::md_fn_t fn,
    input  logic [63:0]      a,
    input  logic [63:0]      b,
    output logic [63:0]      result
);
    import exec_pkg::*;

    logic               div0_d;
    logic               div0_w;
    logic               ovf_w;
    logic [63:0]        divu_q;
    logic [63:0]        remu_r;
    logic [31:0]        mulw_p;
    logic signed [31:0] sq_raw;
    logic signed [31:0] sr_raw;
    logic [31:0]        divw_q;
    logic [31:0]        remw_r;

    assign div0_d = (b == 64'd0);
    assign div0_w = (b[31:0] == 32'd0);
    // most negative word divided by -1
    assign ovf_w  = (a[31:0] == 32'h8000_0000) && (b[31:0] == 32'hffff_ffff);

    assign divu_q = div0_d ? {64{1'b1}} : a / b;
    assign remu_r = div0_d ? a : a % b;
    assign mulw_p = a[31:0] * b[31:0];

    assign sq_raw = $signed(a[31:0]) / $signed(b[31:0]);
    assign sr_raw = $signed(a[31:0]) % $signed(b[31:0]);
    assign divw_q = div0_w ? {32{1'b1}} : (ovf_w ? a[31:0] : sq_raw);
    assign remw_r = div0_w ? a[31:0] : (ovf_w ? 32'd0 : sr_raw);

    always_comb begin
        case (fn)
            DIVU:    result = divu_q;
            REMU:    result = remu_r;
            MULW:    result = {{32{mulw_p[31]}}, mulw_p};
            DIVW:    result = {{32{divw_q[31]}}, divw_q};
            REMW:    result = {{32{remw_r[31]}}, remw_r};
            default: result = 64'd0;
        endcase
    end

endmodule

// File: rtl/lsu_align.sv
module lsu_align (
    input  exec_pkg::op_t op,
    input  logic [63:0]   addr,
    input  logic [63:0]   store_data,
    input  logic [63:0]   rdata,
    output logic [63:0]   wdata,
    output logic [7:0]    wmask,
    output logic [63:0]   load_data
);
    import exec_pkg::*;

    logic [2:0]  lane;
    logic [63:0] ld_shift;

    // first byte lane, forced to the natural alignment of the access
    always_comb begin
        case (op)
            OP_SH, OP_LH, OP_LHU: lane = {addr[2:1], 1'b0};
            OP_SW, OP_LW:         lane = {addr[2], 2'b00};
            OP_SD, OP_LD:         lane = 3'd0;
            default:              lane = addr[2:0];
        endcase
    end

    assign wdata    = store_data << {lane, 3'b000};
    assign ld_shift = rdata >> {lane, 3'b000};

    always_comb begin
        case (op)
            OP_SB:   wmask = 8'h01 << lane;
            OP_SH:   wmask = 8'h03 << lane;
            OP_SW:   wmask = 8'h0f << lane;
            OP_SD:   wmask = 8'hff;
            default: wmask = 8'h00;
        endcase
    end

    always_comb begin
        case (op)
            OP_LB:   load_data = {{56{ld_shift[7]}}, ld_shift[7:0]};
            OP_LBU:  load_data = {56'd0, ld_shift[7:0]};
            OP_LH:   load_data = {{48{ld_shift[15]}}, ld_shift[15:0]};
            OP_LHU:  load_data = {48'd0, ld_shift[15:0]};
            OP_LW:   load_data = {{32{ld_shift[31]}}, ld_shift[31:0]};
            OP_LD:   load_data = rdata;
            default: load_data = 64'd0;
        endcase
    end

    // accesses never straddle a 64-bit word
    always_comb begin
        a_sh_even: assert (!(op == OP_SH) || addr[0] == 1'b0);
        a_sw_word: assert (!(op == OP_SW) || addr[1:0] == 2'b00);
    end

endmodule

// File: rtl/data_ram.sv
module data_ram #(
    parameter int RAM_AW = 8
) (
    input  logic               clk,
    input  exec_pkg::mem_req_t req,
    output logic [63:0]        rdata
);
    logic [63:0]       mem [2**RAM_AW];
    logic [RAM_AW-1:0] idx;

    assign idx   = req.addr[RAM_AW+2:3];
    assign rdata = mem[idx];

    always_ff @(posedge clk) begin
        if (req.we) begin
            for (int i = 0; i < 8; i++) begin
                if (req.wmask[i]) begin
                    mem[idx][i*8 +: 8] <= req.wdata[i*8 +: 8];
                end
            end
        end
    end

endmodule

// File: rtl/exec_unit.sv
module exec_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  exec_pkg::exec_op_t  instr,
    input  logic [63:0]         rdata,
    output exec_pkg::mem_req_t  mem_req,
    output exec_pkg::retire_t   retire,
    output logic [63:0]         dnpc,
    output logic                halt,
    output logic [63:0]         halt_code
);
    import exec_pkg::*;

    logic        live;
    logic        is_store;
    logic        is_ebreak;
    logic        op_writes;
    logic        taken;
    logic [4:0]  rs1_addr;
    logic [63:0] src1;
    logic [63:0] src2;
    logic [63:0] op_a;
    logic [63:0] op_b;
    logic [63:0] alu_res;
    logic [63:0] md_res;
    logic [63:0] load_data;
    logic [63:0] st_wdata;
    logic [7:0]  st_wmask;
    logic [63:0] wb_data;
    logic [63:0] snpc;
    logic [63:0] pc_imm;
    alu_mode_t   alu_mode;
    md_fn_t      md_fn;

    assign live      = rst_n && instr.valid;
    assign is_store  = instr.op inside {OP_SB, OP_SH, OP_SW, OP_SD};
    assign is_ebreak = (instr.op == OP_EBREAK);
    // ebreak borrows the rs1 port to read a0
    assign rs1_addr  = is_ebreak ? 5'd10 : instr.rs1;

    gpr_file gpr_i (
        .clk   (clk),
        .rst_n (rst_n),
        .rs1   (rs1_addr),
        .rs2   (instr.rs2),
        .rd    (retire.rd),
        .wen   (retire.wen),
        .wdata (retire.wdata),
        .src1  (src1),
        .src2  (src2)
    );

    always_comb begin
        case (instr.op)
            OP_SUB, OP_SUBW, OP_BEQ, OP_BNE:     alu_mode = SUB;
            OP_AND:                              alu_mode = AND;
            OP_OR:                               alu_mode = OR;
            OP_XOR:                              alu_mode = XOR;
            OP_SLT, OP_BLT, OP_BGE:              alu_mode = SLT;
            OP_SLTU, OP_SLTIU, OP_BLTU, OP_BGEU: alu_mode = SLTU;
            OP_SLL, OP_SLLI:                     alu_mode = SLL;
            OP_SRL, OP_SRLI:                     alu_mode = SRL;
            OP_SRA, OP_SRAI:                     alu_mode = SRA;
            OP_SLLW:                             alu_mode = SLLW;
            default:                             alu_mode = ADD;
        endcase
    end

    assign op_a = (instr.op == OP_AUIPC) ? instr.pc : src1;

    always_comb begin
        case (instr.op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLTU, OP_ADDW, OP_SUBW,
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: op_b = src2;
            OP_SLL, OP_SRL, OP_SRA:    op_b = {58'd0, src2[5:0]};
            OP_SLLW:                   op_b = {59'd0, src2[4:0]};
            OP_SLLI, OP_SRLI, OP_SRAI: op_b = {58'd0, instr.imm[5:0]};
            default:                   op_b = instr.imm;
        endcase
    end

    int_alu alu_i (
        .mode   (alu_mode),
        .a      (op_a),
        .b      (op_b),
        .result (alu_res)
    );

    always_comb begin
        case (instr.op)
            OP_REMU: md_fn = REMU;
            OP_MULW: md_fn = MULW;
            OP_DIVW: md_fn = DIVW;
            OP_REMW: md_fn = REMW;
            default: md_fn = DIVU;
        endcase
    end

    int_muldiv md_i (
        .fn     (md_fn),
        .a      (src1),
        .b      (src2),
        .result (md_res)
    );

    lsu_align lsu_i (
        .op         (instr.op),
        .addr       (alu_res),
        .store_data (src2),
        .rdata      (rdata),
        .wdata      (st_wdata),
        .wmask      (st_wmask),
        .load_data  (load_data)
    );

    assign mem_req = '{addr: alu_res, wdata: st_wdata, wmask: st_wmask, we: live && is_store};

    always_comb begin
        case (instr.op)
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
            OP_SB, OP_SH, OP_SW, OP_SD, OP_EBREAK, OP_NOP: op_writes = 1'b0;
            default: op_writes = 1'b1;
        endcase
    end

    assign snpc = instr.pc + 64'd4;

    always_comb begin
        case (instr.op)
            OP_ADDW, OP_SUBW, OP_SLLW, OP_ADDIW: wb_data = {{32{alu_res[31]}}, alu_res[31:0]};
            OP_DIVU, OP_REMU, OP_MULW, OP_DIVW, OP_REMW: wb_data = md_res;
            OP_LUI:                              wb_data = instr.imm;
            OP_JAL, OP_JALR:                     wb_data = snpc;
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LD: wb_data = load_data;
            default:                             wb_data = alu_res;
        endcase
    end

    assign retire = '{
        wen:   live && op_writes && (instr.rd != 5'd0),
        rd:    instr.rd,
        wdata: wb_data
    };

    // branch outcome from the sub / compare result
    always_comb begin
        case (instr.op)
            OP_BEQ:          taken = (alu_res == 64'd0);
            OP_BNE:          taken = (alu_res != 64'd0);
            OP_BLT, OP_BLTU: taken = alu_res[0];
            OP_BGE, OP_BGEU: taken = !alu_res[0];
            default:         taken = 1'b0;
        endcase
    end

    assign pc_imm = instr.pc + instr.imm;

    always_comb begin
        if (instr.op == OP_JAL || taken) begin
            dnpc = pc_imm;
        end else if (instr.op == OP_JALR) begin
            dnpc = {alu_res[63:1], 1'b0};
        end else begin
            dnpc = snpc;
        end
    end

    assign halt      = live && is_ebreak;
    assign halt_code = is_ebreak ? src1 : 64'd0;

    a_store_no_wen: assert property (
        @(posedge clk) disable iff (!rst_n) is_store |-> !retire.wen
    );
    a_reset_quiet: assert property (
        @(posedge clk) !rst_n |-> !retire.wen && !halt
    );

endmodule

// File: rtl/exec_core.sv
module exec_core #(
    parameter int RAM_AW = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    input  exec_pkg::exec_op_t instr,
    output exec_pkg::retire_t  retire,
    output logic [63:0]        dnpc,
    output logic               halt,
    output logic [63:0]        halt_code
);
    import exec_pkg::*;

    mem_req_t    mem_req;
    logic [63:0] rdata;

    exec_unit exu_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .instr     (instr),
        .rdata     (rdata),
        .mem_req   (mem_req),
        .retire    (retire),
        .dnpc      (dnpc),
        .halt      (halt),
        .halt_code (halt_code)
    );

    data_ram #(
        .RAM_AW (RAM_AW)
    ) ram_i (
        .clk   (clk),
        .req   (mem_req),
        .rdata (rdata)
    );

endmodule

// File: sim/exec_core_tb.sv
module exec_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import exec_pkg::*;

    localparam int    CLK_PERIOD   = 100;
    localparam int    RESET_CYCLES = 3;
    localparam string VEC_FILE     = "sim/exec_vectors.txt";

    // one instruction plus the outputs it should produce
    typedef struct packed {
        exec_op_t    instr;
        logic        wen;
        logic [4:0]  rd;
        logic [63:0] wdata;
        logic [63:0] dnpc;
        logic        halt;
        logic [63:0] halt_code;
    } vector_t;

    logic        clk;
    logic        rst_n;
    exec_op_t    instr;
    retire_t     retire;
    logic [63:0] dnpc;
    logic        halt;
    logic [63:0] halt_code;

    vector_t vecs[$];
    int      errors = 0;
    int      cycles = 0;
    int      limit = 0;
    string   where = "start";

    exec_core #(
        .RAM_AW (8)
    ) dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .instr     (instr),
        .retire    (retire),
        .dnpc      (dnpc),
        .halt      (halt),
        .halt_code (halt_code)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] want);
        if (got !== want) begin
            $display("[ERROR] %s %s: got %h expected %h", where, name, got, want);
            errors++;
        end
    endtask

    task automatic compare_outputs(input vector_t v);
        check("retire.wen", {63'd0, retire.wen}, {63'd0, v.wen});
        check("retire.rd", {59'd0, retire.rd}, {59'd0, v.rd});
        // write data only matters when the write is enabled
        if (v.wen) begin
            check("retire.wdata", retire.wdata, v.wdata);
        end
        check("dnpc", dnpc, v.dnpc);
        check("halt", {63'd0, halt}, {63'd0, v.halt});
        if (v.halt) begin
            check("halt_code", halt_code, v.halt_code);
        end
    endtask

    // file holds mnemonics without the OP_ prefix
    function automatic bit find_op(input string name, output op_t op);
        op_t cand;
        cand = cand.first();
        op = OP_NOP;
        for (int i = 0; i < cand.num(); i++) begin
            if (cand.name() == {"OP_", name}) begin
                op = cand;
                return 1'b1;
            end
            cand = cand.next();
        end
        return 1'b0;
    endfunction

    task automatic load_vectors;
        int          fd;
        int          n;
        int          valid;
        int          rd;
        int          rs1;
        int          rs2;
        int          wen;
        int          erd;
        int          hlt;
        string       line;
        string       name;
        logic [63:0] imm;
        logic [63:0] pc;
        logic [63:0] wdata;
        logic [63:0] npc;
        logic [63:0] code;
        op_t         op;
        vector_t     v;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("could not open the vector file %s", VEC_FILE);
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%d %s %d %d %d %h %h %d %d %h %h %d %h", valid, name,
                        rd, rs1, rs2, imm, pc, wen, erd, wdata, npc, hlt, code);
            if (n != 13 || !find_op(name, op)) begin
                $display("could not parse vector line: %s", line);
                errors++;
                continue;
            end
            v = '0;
            v.instr.valid = valid[0];
            v.instr.op    = op;
            v.instr.rd    = rd[4:0];
            v.instr.rs1   = rs1[4:0];
            v.instr.rs2   = rs2[4:0];
            v.instr.imm   = imm;
            v.instr.pc    = pc;
            v.wen         = wen[0];
            v.rd          = erd[4:0];
            v.wdata       = wdata;
            v.dnpc        = npc;
            v.halt        = hlt[0];
            v.halt_code   = code;
            vecs.push_back(v);
        end
        $fclose(fd);
        if (vecs.size() == 0) begin
            $display("the vector file held no usable lines");
            errors++;
        end
    endtask

    always @(posedge clk) begin
        if (cycles >= limit) begin
            $display("timeout: the run was still going after %0d cycles", cycles);
            $display("STATUS: FAIL");
            $finish;
        end else begin
            cycles <= cycles + 1;
        end
    end

    initial begin
        exec_op_t rst_op;
        rst_n = 1'b0;
        instr = '0;
        load_vectors();
        limit = vecs.size() + RESET_CYCLES + 20;

        // valid ops under reset must neither retire nor halt
        for (int i = 0; i < RESET_CYCLES; i++) begin
            rst_op       = '0;
            rst_op.valid = 1'b1;
            rst_op.op    = (i == 1) ? OP_EBREAK : OP_ADDI;
            rst_op.rd    = 5'd5;
            rst_op.imm   = 64'h55;
            rst_op.pc    = 64'h0ff0;
            @(posedge clk);
            instr <= rst_op;
            @(negedge clk);
            where = $sformatf("reset cycle %0d", i + 1);
            check("retire.wen", {63'd0, retire.wen}, 64'd0);
            check("halt", {63'd0, halt}, 64'd0);
        end

        for (int i = 0; i < vecs.size(); i++) begin
            @(posedge clk);
            rst_n <= 1'b1;
            instr <= vecs[i].instr;
            @(negedge clk);
            where = $sformatf("vector %0d", i + 1);
            compare_outputs(vecs[i]);
        end
        @(posedge clk);
        instr <= '0;

        $display("vectors run: %0d, errors: %0d", vecs.size(), errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: exec_core.f
rtl/exec_pkg.sv
rtl/gpr_file.sv
rtl/int_alu.sv
rtl/int_muldiv.sv
rtl/lsu_align.sv
rtl/data_ram.sv
rtl/exec_unit.sv
rtl/exec_core.sv
sim/exec_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= exec_core_tb
FILELIST  ?= exec_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP), look for the pass line in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/exec_vectors.txt
# valid op rd rs1 rs2 imm pc | expected wen rd wdata dnpc halt halt_code
# valid, rd, rs1, rs2, wen, rd, halt in decimal; imm, pc, wdata, dnpc, halt_code in hex
1 ADD     3  5 10 0                1000 1  3 0                1004     0 0
1 ADDI    1  0  0 fffffffffffffffb 1004 1  1 fffffffffffffffb 1008     0 0
1 ADDI    2  0  0 7                1008 1  2 7                100c     0 0
1 ADDI   10  0  0 2a               100c 1 10 2a               1010     0 0
1 SRA     4  1  2 0                1010 1  4 ffffffffffffffff 1014     0 0
1 SRL     5  1  2 0                1014 1  5 01ffffffffffffff 1018     0 0
1 SLTU    6  2  1 0                1018 1  6 1                101c     0 0
1 SLT     7  2  1 0                101c 1  7 0                1020     0 0
1 LUI     9  0  0 7ffff000         1020 1  9 7ffff000         1024     0 0
1 ADDW    8  9  9 0                1024 1  8 ffffffffffffe000 1028     0 0
1 SUBW   11  0  2 0                1028 1 11 fffffffffffffff9 102c     0 0
1 SLLW   12  9  2 0                102c 1 12 fffffffffff80000 1030     0 0
1 ADD     0  2  2 0                1030 0  0 0                1034     0 0
1 OR     13  2  9 0                1034 1 13 7ffff007         1038     0 0
1 SUB    14  2  9 0                1038 1 14 ffffffff80001007 103c     0 0
1 AUIPC  15  0  0 1000             103c 1 15 203c             1040     0 0
1 DIVU   16  9  2 0                1040 1 16 12492249         1044     0 0
1 REMU   17  9  2 0                1044 1 17 1                1048     0 0
1 DIVU   18  9  0 0                1048 1 18 ffffffffffffffff 104c     0 0
1 MULW   19 11  2 0                104c 1 19 ffffffffffffffcf 1050     0 0
1 DIVW   20  8  2 0                1050 1 20 fffffffffffffb6e 1054     0 0
1 REMW   21  8  2 0                1054 1 21 fffffffffffffffe 1058     0 0
1 REMW   22  8  0 0                1058 1 22 ffffffffffffe000 105c     0 0
1 SD      5  0  1 100              105c 0  5 0                1060     0 0
1 SB      0  0  2 102              1060 0  0 0                1064     0 0
1 SH      0  0  9 106              1064 0  0 0                1068     0 0
1 SD      0  0  0 108              1068 0  0 0                106c     0 0
1 SW      0  0 11 10c              106c 0  0 0                1070     0 0
1 SB      0  0  1 10b              1070 0  0 0                1074     0 0
1 LD     23  0  0 100              1074 1 23 f000ffffff07fffb 1078     0 0
1 LB     24  0  0 102              1078 1 24 7                107c     0 0
1 LBU    25  0  0 100              107c 1 25 fb               1080     0 0
1 LH     26  0  0 106              1080 1 26 fffffffffffff000 1084     0 0
1 LHU    27  0  0 106              1084 1 27 f000             1088     0 0
1 LW     28  0  0 10c              1088 1 28 fffffffffffffff9 108c     0 0
1 LW     29  0  0 108              108c 1 29 fffffffffb000000 1090     0 0
1 LHU    30  0  0 102              1090 1 30 ff07             1094     0 0
1 JAL     5  0  0 40               1094 1  5 1098             10d4     0 0
1 JALR    6 13  0 10               1098 1  6 109c             7ffff016 0 0
1 BEQ     0  2  2 fffffffffffffff0 109c 0  0 0                108c     0 0
1 BEQ     0  1  2 20               10a0 0  0 0                10a4     0 0
1 BNE     0  1  2 20               10a4 0  0 0                10c4     0 0
1 BNE     0  2  2 20               10a8 0  0 0                10ac     0 0
1 BLT     0  1  2 20               10ac 0  0 0                10cc     0 0
1 BLT     0  2  1 20               10b0 0  0 0                10b4     0 0
1 BGE     0  2  1 20               10b4 0  0 0                10d4     0 0
1 BGE     0  1  2 20               10b8 0  0 0                10bc     0 0
1 BLTU    0  2  1 20               10bc 0  0 0                10dc     0 0
1 BLTU    0  1  2 20               10c0 0  0 0                10c4     0 0
1 BGEU    0  1  2 20               10c4 0  0 0                10e4     0 0
1 BGEU    0  2  1 20               10c8 0  0 0                10cc     0 0
1 NOP     0  0  0 0                10cc 0  0 0                10d0     0 0
0 ADDI   12  0  0 55               10d0 0 12 0                10d4     0 0
1 ADD     3 12  0 0                10d4 1  3 fffffffffff80000 10d8     0 0
0 EBREAK  0  0  0 0                10d8 0  0 0                10dc     0 0
1 EBREAK  0  0  0 0                10dc 0  0 0                10e0     1 2a
